//--- Bender.yml
package:
  name: decode_frontend

sources:
  - include_dirs:
      - include
    files:
      - hw/decode_pkg.sv
      - hw/fetch_bundle_fifo.sv
      - hw/instr_class_decoder.sv
      - hw/decode_frontend.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_decode_frontend.sv

//--- hw/decode_frontend.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_frontend
(
    input  logic                                      clk_i,
    input  logic                                      rst_i,

    // Fetch bundle input
    input  decode_pkg::fetch_bundle_t                 bundle_i,
    input  logic                                      bundle_valid_i,
    output logic                                      bundle_accept_o,

    // Branch flush
    input  logic                                      branch_request_i,

    // Per slot outputs
    output decode_pkg::slot_t [`DEC_SLOTS-1:0]        slot_o,
    output logic [`DEC_SLOTS-1:0]                     slot_valid_o,
    output decode_pkg::instr_class_t [`DEC_SLOTS-1:0] class_o,
    input  logic [`DEC_SLOTS-1:0]                     slot_accept_i
);

    // --------------------------------------------------
    // Bundle buffer
    // --------------------------------------------------
    fetch_bundle_fifo u_fifo
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (branch_request_i),
        .push_i       (bundle_valid_i),
        .bundle_i     (bundle_i),
        .accept_o     (bundle_accept_o),
        .slot_o       (slot_o),
        .slot_valid_o (slot_valid_o),
        .pop_i        (slot_accept_i)
    );

    // --------------------------------------------------
    // One decoder per slot after the buffer
    // --------------------------------------------------
    for (genvar k = 0; k < `DEC_SLOTS; k++)
    begin : g_dec
        instr_class_decoder u_dec
        (
            .clk_i   (clk_i),
            .valid_i (slot_valid_o[k]),
            .slot_i  (slot_o[k]),
            .class_o (class_o[k])
        );
    end

endmodule

//--- hw/decode_pkg.sv
package decode_pkg;

    // --------------------------------------------------
    // Basic widths
    // --------------------------------------------------
    typedef logic [31:0]  instr_t;
    typedef logic [31:0]  pc_t;
    typedef logic [127:0] bundle_data_t;

    // Valid slots minus one
    typedef logic [1:0]   slot_cnt_t;

    // Fetch bundle with slot 0 in the low word
    typedef struct packed {
        pc_t          pc;
        slot_cnt_t    count;
        logic         fault_fetch;
        logic         fault_page;
        bundle_data_t data;
    } fetch_bundle_t;

    // One instruction on its way to issue
    typedef struct packed {
        pc_t    pc;
        instr_t instr;
        logic   fault_fetch;
        logic   fault_page;
    } slot_t;

    // Functional unit classes plus destination write
    typedef struct packed {
        logic invalid;
        logic exec;
        logic lsu;
        logic branch;
        logic mul;
        logic div;
        logic csr;
        logic rd_valid;
    } instr_class_t;

    // RV32 major opcodes
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_e;

endpackage

//--- hw/fetch_bundle_fifo.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module fetch_bundle_fifo
(
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               flush_i,
    input  logic                               push_i,
    input  decode_pkg::fetch_bundle_t          bundle_i,
    output logic                               accept_o,
    output decode_pkg::slot_t [`DEC_SLOTS-1:0] slot_o,
    output logic [`DEC_SLOTS-1:0]              slot_valid_o,
    input  logic [`DEC_SLOTS-1:0]              pop_i
);
    import decode_pkg::*;

    localparam int unsigned SLOTS = `DEC_SLOTS;
    localparam int unsigned DEPTH = `DEC_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    // Entry payload
    pc_t              pc_q          [DEPTH];
    bundle_data_t     data_q        [DEPTH];
    logic             fault_fetch_q [DEPTH];
    logic             fault_page_q  [DEPTH];

    // Per entry, per slot still to be taken
    logic [SLOTS-1:0] valid_q       [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;

    logic             not_empty_w;
    logic             push_w;
    logic             retire_w;
    logic [SLOTS-1:0] pop_w;
    logic [SLOTS-1:0] push_valid_w;
    bundle_data_t     push_data_w;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------
    assign not_empty_w  = (count_q != '0);
    assign accept_o     = (count_q != FULL_CNT);
    // A flush edge neither pushes nor pops
    assign push_w       = push_i & accept_o & ~flush_i;
    assign slot_valid_o = not_empty_w ? valid_q[rd_ptr_q] : '0;
    assign pop_w        = pop_i & slot_valid_o;
    // Head is done once each slot is taken or leaving now
    assign retire_w     = not_empty_w & (&(pop_w | ~slot_valid_o));

    // Faulted fetches carry no instruction data
    assign push_data_w  = (bundle_i.fault_fetch | bundle_i.fault_page) ? '0 : bundle_i.data;

    // --------------------------------------------------
    // Slot packing
    // --------------------------------------------------
    for (genvar k = 0; k < SLOTS; k++)
    begin : g_slot
        assign push_valid_w[k]      = (slot_cnt_t'(k) <= bundle_i.count);
        assign slot_o[k].pc         = {pc_q[rd_ptr_q][31:4], 4'(k * 4)};
        assign slot_o[k].instr      = data_q[rd_ptr_q][k*32 +: 32];
        assign slot_o[k].fault_fetch = fault_fetch_q[rd_ptr_q];
        assign slot_o[k].fault_page = fault_page_q[rd_ptr_q];
    end

    // --------------------------------------------------
    // Control state
    // --------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            for (int i = 0; i < DEPTH; i++)
                valid_q[i] <= '0;
        end
        else if (flush_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            for (int i = 0; i < DEPTH; i++)
                valid_q[i] <= '0;
        end
        else
        begin
            // Drop slots as they transfer
            valid_q[rd_ptr_q] <= valid_q[rd_ptr_q] & ~pop_w;

            if (push_w)
            begin
                valid_q[wr_ptr_q] <= push_valid_w;
                wr_ptr_q          <= ptr_inc(wr_ptr_q);
            end

            if (retire_w)
                rd_ptr_q <= ptr_inc(rd_ptr_q);

            if (push_w && !retire_w)
                count_q <= count_q + 1'b1;
            else if (!push_w && retire_w)
                count_q <= count_q - 1'b1;
        end
    end

    // Payload written on push only
    always_ff @(posedge clk_i)
    begin
        if (push_w)
        begin
            pc_q[wr_ptr_q]          <= bundle_i.pc;
            data_q[wr_ptr_q]        <= push_data_w;
            fault_fetch_q[wr_ptr_q] <= bundle_i.fault_fetch;
            fault_page_q[wr_ptr_q]  <= bundle_i.fault_page;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    // Full buffer takes nothing until the head leaves
    assert property (@(posedge clk_i) disable iff (rst_i)
        (count_q == FULL_CNT) && !retire_w && !flush_i
        |=> $stable(wr_ptr_q) && (count_q == FULL_CNT));

    assert property (@(posedge clk_i) disable iff (rst_i)
        count_q <= FULL_CNT);

endmodule

//--- hw/instr_class_decoder.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module instr_class_decoder
(
    input  logic                     clk_i,
    input  logic                     valid_i,
    input  decode_pkg::slot_t        slot_i,
    output decode_pkg::instr_class_t class_o
);
    import decode_pkg::*;

    localparam bit MULDIV_EN = (`DEC_SUPPORT_MULDIV != 0);

    opcode_e      opcode;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic [4:0]   rd;
    logic         active;
    logic         rd_write;
    logic         unit_hit;
    instr_class_t units;

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------
    assign opcode = opcode_e'(slot_i.instr[6:0]);
    assign funct3 = slot_i.instr[14:12];
    assign funct7 = slot_i.instr[31:25];
    assign rd     = slot_i.instr[11:7];

    // Faulted slots decode to nothing
    assign active = valid_i & ~(slot_i.fault_fetch | slot_i.fault_page);

    always_comb
    begin
        units    = '0;
        rd_write = 1'b0;
        case (opcode)
            LUI, AUIPC, OP_IMM:
            begin
                units.exec = 1'b1;
                rd_write   = 1'b1;
            end
            MISC_MEM:
                units.exec = 1'b1;
            JAL, JALR:
            begin
                units.branch = 1'b1;
                rd_write     = 1'b1;
            end
            BRANCH:
                units.branch = 1'b1;
            LOAD:
            begin
                units.lsu = 1'b1;
                rd_write  = 1'b1;
            end
            STORE:
                units.lsu = 1'b1;
            OP:
            begin
                rd_write = 1'b1;
                if (funct7 != 7'b0000001)
                    units.exec = 1'b1;
                else if (MULDIV_EN)
                begin
                    // funct3 MSB splits mul from div
                    units.mul = ~funct3[2];
                    units.div = funct3[2];
                end
            end
            SYSTEM:
            begin
                units.csr = 1'b1;
                rd_write  = (funct3 != 3'b000);
            end
            default:
                units = '0;
        endcase
    end

    assign unit_hit = units.exec | units.lsu | units.branch |
                      units.mul | units.div | units.csr;

    // --------------------------------------------------
    // Output
    // --------------------------------------------------
    always_comb
    begin
        class_o = '0;
        if (active)
        begin
            class_o          = units;
            class_o.invalid  = ~unit_hit;
            // No write back for rejected or x0 destinations
            class_o.rd_valid = rd_write & unit_hit & (rd != 5'd0);
        end
    end

    assert property (@(posedge clk_i)
        $onehot0({class_o.exec, class_o.lsu, class_o.branch,
                  class_o.mul, class_o.div, class_o.csr}));

endmodule

//--- include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// --------------------------------------------------
// Decode frontend build options
// --------------------------------------------------

// Instructions per fetch bundle
`define DEC_SLOTS 4

// Bundle buffer entries
`define DEC_FIFO_DEPTH 2

// 1 enables the mul and div unit classes
`define DEC_SUPPORT_MULDIV 1

`endif

//--- sim/decode_golden.txt
# P pc count fault_fetch fault_page word0 word1 word2 word3 / E slot pc instr class / F flush
# class bits from msb: invalid exec lsu branch mul div csr rd_valid
P 00001000 3 0 0 00500093 0080A103 0020A623 00208063
E 0 00001000 00500093 41
E 1 00001004 0080A103 21
E 2 00001008 0020A623 20
E 3 0000100C 00208063 10
P 00001010 3 0 0 022081B3 0220C233 00208033 02209033
E 0 00001010 022081B3 09
E 1 00001014 0220C233 05
E 2 00001018 00208033 40
E 3 0000101C 02209033 08
P 00002000 3 0 0 123452B7 00008067 300093F3 0000005B
E 0 00002000 123452B7 41
E 1 00002004 00008067 10
E 2 00002008 300093F3 03
E 3 0000200C 0000005B 80
P 00003010 1 0 0 00000090 00000073 DEADBEEF CAFEF00D
E 0 00003010 00000090 80
E 1 00003014 00000073 02
P 00003020 2 0 0 00014503 0FF0000F 000000EF 12345678
E 0 00003020 00014503 21
E 1 00003024 0FF0000F 40
E 2 00003028 000000EF 11
P 00004000 1 1 0 00500093 0080A103 00208063 00208063
E 0 00004000 00000000 00
E 1 00004004 00000000 00
P 00004014 0 0 1 00108093 11111111 22222222 33333333
E 0 00004010 00000000 00
P 00005000 3 0 0 00500093 0080A103 0020A623 00208063
E 0 00005000 00500093 41
E 1 00005004 0080A103 21
E 2 00005008 0020A623 20
E 3 0000500C 00208063 10
P 00005010 1 0 0 022081B3 0220C233 00000000 00000000
E 0 00005010 022081B3 09
E 1 00005014 0220C233 05
F
P 00006000 3 0 0 0220F2B3 02209033 00001317 00108093
E 0 00006000 0220F2B3 05
E 1 00006004 02209033 08
E 2 00006008 00001317 41
E 3 0000600C 00108093 41

//--- sim/tb_decode_frontend.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module tb_decode_frontend;
    import decode_pkg::*;

    // One expected slot transfer
    typedef struct packed {
        logic [1:0]   slot;
        slot_t        s;
        instr_class_t cls;
    } expect_t;

    logic                               clk_i = 1'b0;
    logic                               rst_i;
    fetch_bundle_t                      bundle_i;
    logic                               bundle_valid_i;
    logic                               bundle_accept_o;
    logic                               branch_request_i;
    slot_t [`DEC_SLOTS-1:0]             slot_o;
    logic [`DEC_SLOTS-1:0]              slot_valid_o;
    instr_class_t [`DEC_SLOTS-1:0]      class_o;
    logic [`DEC_SLOTS-1:0]              slot_accept_i;

    expect_t                exp_q[$];
    // Slots still to be taken, one entry per buffered bundle
    logic [`DEC_SLOTS-1:0]  mask_q[$];
    int            errors = 0;
    int            checks = 0;
    int            cycles = 0;
    int            limit = 100;
    bit            seen_full = 1'b0;
    integer        seed = 63214;

    always #10 clk_i = ~clk_i;

    decode_frontend u_dut
    (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .bundle_i         (bundle_i),
        .bundle_valid_i   (bundle_valid_i),
        .bundle_accept_o  (bundle_accept_o),
        .branch_request_i (branch_request_i),
        .slot_o           (slot_o),
        .slot_valid_o     (slot_valid_o),
        .class_o          (class_o),
        .slot_accept_i    (slot_accept_i)
    );

    // Each slot accepts about one cycle in four
    always @(posedge clk_i)
    begin
        slot_accept_i <= $random(seed) & $random(seed);
    end

    task automatic finish_run();
        $display("Run ended after %0d cycles: %0d checks, %0d errors", cycles, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    endtask

    always @(posedge clk_i)
    begin
        cycles = cycles + 1;
        if (cycles > limit)
        begin
            $display("Timeout with %0d expected slots never delivered", exp_q.size());
            errors = errors + 1;
            finish_run();
        end
    end

    // Oldest outstanding expectation for a slot index
    function automatic int find_expect(input int k);
        for (int i = 0; i < exp_q.size(); i++)
        begin
            if (exp_q[i].slot == k)
                return i;
        end
        return -1;
    endfunction

    task automatic check_slot(input int k, input expect_t e);
        checks = checks + 2;
        if (slot_o[k] !== e.s)
        begin
            $display("error slot_o[%0d]: got %h expected %h", k, slot_o[k], e.s);
            errors = errors + 1;
        end
        if (class_o[k] !== e.cls)
        begin
            $display("error class_o[%0d]: got %h expected %h", k, class_o[k], e.cls);
            errors = errors + 1;
        end
    endtask

    // Caller sits just after a rising edge
    task automatic push_bundle(input fetch_bundle_t b);
        bundle_i       <= b;
        bundle_valid_i <= 1'b1;
        @(negedge clk_i);
        while (!bundle_accept_o)
            @(negedge clk_i);
        @(posedge clk_i);
    endtask

    // --------------------------------------------------
    // Monitor sampling mid cycle
    // --------------------------------------------------
    always @(negedge clk_i)
    begin : monitor
        logic [`DEC_SLOTS-1:0] exp_valid;
        logic [`DEC_SLOTS-1:0] moved;
        logic [`DEC_SLOTS-1:0] fresh;
        bit                    room;
        int                    idx;
        if (!rst_i && branch_request_i)
        begin
            exp_q.delete();
            mask_q.delete();
        end
        else if (!rst_i)
        begin
            exp_valid = (mask_q.size() > 0) ? mask_q[0] : '0;
            room      = (mask_q.size() < `DEC_FIFO_DEPTH);
            checks    = checks + 2;
            if (bundle_accept_o !== room)
            begin
                $display("error bundle_accept_o: got %h expected %h", bundle_accept_o, room);
                errors = errors + 1;
            end
            if (slot_valid_o !== exp_valid)
            begin
                $display("error slot_valid_o: got %h expected %h", slot_valid_o, exp_valid);
                errors = errors + 1;
            end
            moved = exp_valid & slot_accept_i;
            for (int k = 0; k < `DEC_SLOTS; k++)
            begin
                if (!exp_valid[k] && class_o[k] !== '0)
                begin
                    $display("error class_o[%0d]: got %h expected 00", k, class_o[k]);
                    errors = errors + 1;
                end
                if (moved[k])
                begin
                    idx = find_expect(k);
                    if (idx < 0)
                    begin
                        $display("Slot %0d transferred with nothing expected there", k);
                        errors = errors + 1;
                    end
                    else
                    begin
                        check_slot(k, exp_q[idx]);
                        exp_q.delete(idx);
                    end
                end
            end
            // Head retires once all its slots are gone
            if (mask_q.size() > 0)
            begin
                if ((mask_q[0] & ~moved) == '0)
                    void'(mask_q.pop_front());
                else
                    mask_q[0] = mask_q[0] & ~moved;
            end
            // Slots up to the count are valid
            if (bundle_valid_i && room)
            begin
                for (int k = 0; k < `DEC_SLOTS; k++)
                    fresh[k] = (k <= int'(bundle_i.count));
                mask_q.push_back(fresh);
            end
            if (mask_q.size() == `DEC_FIFO_DEPTH)
                seen_full = 1'b1;
        end
    end

    // --------------------------------------------------
    // Golden file replay
    // --------------------------------------------------
    initial
    begin : replay
        integer        fd;
        integer        rc;
        logic [63:0]   tag;
        logic [1599:0] line;
        logic [31:0]   pc;
        logic [31:0]   word;
        logic [1:0]    cnt;
        logic [1:0]    slot;
        logic          ff;
        logic          fp;
        logic [7:0]    cls;
        bundle_data_t  data;
        fetch_bundle_t pend;
        bit            have_pend;
        have_pend        = 1'b0;
        pend             = '0;
        rst_i            = 1'b1;
        bundle_i         = '0;
        bundle_valid_i   = 1'b0;
        branch_request_i = 1'b0;
        slot_accept_i    = '0;
        fd = $fopen("sim/decode_golden.txt", "r");
        repeat (10) @(posedge clk_i);
        rst_i <= 1'b0;

        if (fd == 0)
        begin
            $display("Cannot open the golden file sim/decode_golden.txt");
            errors = errors + 1;
        end
        else
        begin
            while ($fscanf(fd, "%s", tag) == 1)
            begin
                if (tag == "#")
                    rc = $fgets(line, fd);
                else if (tag == "P")
                begin
                    limit = limit + 40;
                    rc = $fscanf(fd, "%h %h %h %h", pc, cnt, ff, fp);
                    for (int i = 0; i < `DEC_SLOTS; i++)
                    begin
                        rc = $fscanf(fd, "%h", word);
                        data[i*32 +: 32] = word;
                    end
                    if (have_pend)
                        push_bundle(pend);
                    pend      = {pc, cnt, ff, fp, data};
                    have_pend = 1'b1;
                end
                else if (tag == "E")
                begin
                    limit = limit + 40;
                    rc = $fscanf(fd, "%h %h %h %h", slot, pc, word, cls);
                    exp_q.push_back({slot, pc, word, pend.fault_fetch, pend.fault_page, cls});
                end
                else if (tag == "F")
                begin
                    limit = limit + 40;
                    if (have_pend)
                        push_bundle(pend);
                    have_pend        = 1'b0;
                    bundle_valid_i   <= 1'b0;
                    branch_request_i <= 1'b1;
                    @(posedge clk_i);
                    branch_request_i <= 1'b0;
                end
            end
            if (have_pend)
                push_bundle(pend);
            bundle_valid_i <= 1'b0;
            $fclose(fd);

            // Drain whatever is still buffered
            while (exp_q.size() != 0 || mask_q.size() != 0)
                @(posedge clk_i);
            repeat (2) @(posedge clk_i);
            if (!seen_full)
            begin
                $display("The bundle FIFO never filled, so accept back-pressure went untested");
                errors = errors + 1;
            end
        end
        finish_run();
    end

endmodule

//--- tb.f
+incdir+include
hw/decode_pkg.sv
hw/fetch_bundle_fifo.sv
hw/instr_class_decoder.sv
hw/decode_frontend.sv
sim/tb_decode_frontend.sv
